// ==== rtl/rv32i_types.sv ====
package rv32i_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ARCH_REGS     = 32;
    localparam int PHYS_REG_BITS = 6;   // default, overridden from the top
    localparam int ROB_TAG_BITS  = 6;

    // base opcodes
    localparam logic [6:0] op_b_reg   = 7'b0110011;
    localparam logic [6:0] op_b_imm   = 7'b0010011;
    localparam logic [6:0] op_b_lui   = 7'b0110111;
    localparam logic [6:0] op_b_auipc = 7'b0010111;
    localparam logic [6:0] op_b_jal   = 7'b1101111;
    localparam logic [6:0] op_b_jalr  = 7'b1100111;
    localparam logic [6:0] op_b_br    = 7'b1100011;
    localparam logic [6:0] op_b_load  = 7'b0000011;
    localparam logic [6:0] op_b_store = 7'b0100011;

    // M extension funct3
    localparam logic [2:0] mult_div_f3_mul    = 3'b000;
    localparam logic [2:0] mult_div_f3_mulh   = 3'b001;
    localparam logic [2:0] mult_div_f3_mulhsu = 3'b010;
    localparam logic [2:0] mult_div_f3_mulhu  = 3'b011;
    localparam logic [2:0] mult_div_f3_div    = 3'b100;
    localparam logic [2:0] mult_div_f3_divu   = 3'b101;
    localparam logic [2:0] mult_div_f3_rem    = 3'b110;
    localparam logic [2:0] mult_div_f3_remu   = 3'b111;

    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef enum logic [1:0] {
        rs_alu = 2'b00,
        rs_mul = 2'b01,
        rs_div = 2'b10
    } rs_class_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word, two overlays of the same 32 bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [19:0] upper;     // inst[31:12]
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_view;
    } inst_u;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
        logic [31:0] u_imm;
        logic [31:0] j_imm;
        logic [4:0]  rd_s;
        logic [4:0]  rs1_s;
        logic [4:0]  rs2_s;
        logic [31:0] inst;
    } decode_info_t;

    typedef struct packed {
        decode_info_t              decode_info;
        rs_class_t                 rs_class;
        logic [PHYS_REG_BITS-1:0]  pd;
        logic [PHYS_REG_BITS-1:0]  ps1;
        logic [PHYS_REG_BITS-1:0]  ps2;
        logic                      ps1_valid;
        logic                      ps2_valid;
        logic                      regf_we;
        logic [ROB_TAG_BITS-1:0]   rob_num;
    } dispatch_pkt_t;

endpackage : rv32i_types

// ==== rtl/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
    parameter int DEPTH = 8
)
(
    input   logic                   clk,
    input   logic                   reset,

    // fetch side
    input   logic                   fetch_valid,
    input   rv32i_types::inst_u     fetch_inst,
    output  logic                   fetch_ready,

    // dispatch side
    output  rv32i_types::inst_u     head_inst,
    output  logic                   is_iqueue_empty,
    input   logic                   iq_dequeue
);

    import rv32i_types::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    inst_u                 ring [DEPTH];
    logic [PTR_BITS-1:0]   rd_ptr, wr_ptr;
    logic [CNT_BITS-1:0]   count;
    logic                  push, pop;

    assign fetch_ready     = (count != CNT_BITS'(DEPTH));
    assign is_iqueue_empty = (count == '0);
    assign head_inst       = ring[rd_ptr];

    assign push = fetch_valid && fetch_ready;
    assign pop  = iq_dequeue && !is_iqueue_empty;   // ignore pops when empty

    always_ff @(posedge clk) begin
        if (push) begin
            ring[wr_ptr] <= fetch_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : inst_queue

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps

module free_list #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS
)
(
    input   logic                       clk,
    input   logic                       reset,

    // rename side
    input   logic                       fl_dequeue,
    output  logic [PHYS_REG_BITS-1:0]   phys_reg,
    output  logic                       is_free_list_empty,

    // commit side
    input   logic                       release_valid,
    input   logic [PHYS_REG_BITS-1:0]   release_preg
);

    import rv32i_types::*;

    // only the registers above the architectural range circulate
    localparam int FL_DEPTH = (1 << PHYS_REG_BITS) - ARCH_REGS;
    localparam int PTR_BITS = (FL_DEPTH > 1) ? $clog2(FL_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FL_DEPTH + 1);

    logic [PHYS_REG_BITS-1:0]  ring [FL_DEPTH];
    logic [PTR_BITS-1:0]       head_ptr, tail_ptr;
    logic [CNT_BITS-1:0]       count;
    logic                      is_full;
    logic                      push, pop;

    assign is_free_list_empty = (count == '0);
    assign is_full            = (count == CNT_BITS'(FL_DEPTH));
    assign phys_reg           = ring[head_ptr];

    assign pop  = fl_dequeue && !is_free_list_empty;
    assign push = release_valid && (!is_full || pop);   // overflow guard

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                ring[i] <= PHYS_REG_BITS'(ARCH_REGS + i);   // 32 .. top
            end
            head_ptr <= '0;
            tail_ptr <= '0;                     // full ring, tail wraps onto head
            count    <= CNT_BITS'(FL_DEPTH);
        end else begin
            if (push) begin
                ring[tail_ptr] <= release_preg;
                tail_ptr <= (tail_ptr == PTR_BITS'(FL_DEPTH - 1)) ? '0 : tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= (head_ptr == PTR_BITS'(FL_DEPTH - 1)) ? '0 : head_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : free_list

// ==== rtl/rat.sv ====
`timescale 1ns/1ps

module rat #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS
)
(
    input   logic                       clk,
    input   logic                       reset,

    // source lookups
    input   logic [4:0]                 rs1,
    input   logic [4:0]                 rs2,
    output  logic [PHYS_REG_BITS-1:0]   ps1,
    output  logic [PHYS_REG_BITS-1:0]   ps2,
    output  logic                       ps1_valid,
    output  logic                       ps2_valid,

    // destination rename
    input   logic [4:0]                 rd,
    input   logic                       rat_we,
    input   logic [PHYS_REG_BITS-1:0]   pd,

    // completion broadcast
    input   logic                       cdb_valid,
    input   logic [PHYS_REG_BITS-1:0]   cdb_preg
);

    import rv32i_types::*;

    logic [PHYS_REG_BITS-1:0]  map_table [ARCH_REGS];
    logic [ARCH_REGS-1:0]      ready_bits;
    logic                      rs1_woken, rs2_woken;

    // a result on the bus this cycle counts as ready already
    assign rs1_woken = cdb_valid && (map_table[rs1] == cdb_preg);
    assign rs2_woken = cdb_valid && (map_table[rs2] == cdb_preg);

    assign ps1       = map_table[rs1];
    assign ps2       = map_table[rs2];
    assign ps1_valid = ready_bits[rs1] || rs1_woken;
    assign ps2_valid = ready_bits[rs2] || rs2_woken;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_table[i] <= PHYS_REG_BITS'(i);  // identity mapping
            end
            ready_bits <= '1;
        end else begin
            // wakeup first, x0 never changes
            for (int i = 1; i < ARCH_REGS; i++) begin
                if (cdb_valid && (map_table[i] == cdb_preg)) begin
                    ready_bits[i] <= 1'b1;
                end
            end
            // a rename overrides a wakeup of the same entry
            if (rat_we && (rd != 5'd0)) begin
                map_table[rd]  <= pd;
                ready_bits[rd] <= 1'b0;
            end
        end
    end

endmodule : rat

// ==== rtl/rename_dispatch.sv ====
`timescale 1ns/1ps

module rename_dispatch #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS
)
(
    input   logic                               clk,
    input   logic                               reset,

    // instruction queue
    input   rv32i_types::inst_u                 head_inst,
    input   logic                               is_iqueue_empty,
    output  logic                               iq_dequeue,

    // free list
    input   logic [PHYS_REG_BITS-1:0]           phys_reg,
    input   logic                               is_free_list_empty,
    output  logic                               fl_dequeue,

    // RAT
    output  logic [4:0]                         rd,
    output  logic [4:0]                         rs1,
    output  logic [4:0]                         rs2,
    output  logic [PHYS_REG_BITS-1:0]           pd,
    output  logic                               rat_we,
    input   logic [PHYS_REG_BITS-1:0]           ps1,
    input   logic [PHYS_REG_BITS-1:0]           ps2,
    input   logic                               ps1_valid,
    input   logic                               ps2_valid,

    // back-end state
    input   logic                               rob_full,
    input   logic                               rs_full_add,
    input   logic                               rs_full_mul,
    input   logic                               rs_full_div,
    input   logic [rv32i_types::ROB_TAG_BITS-1:0] rob_num,

    output  logic                               dispatch_valid,
    output  rv32i_types::dispatch_pkt_t         dispatch_pkt
);

    import rv32i_types::*;

    decode_info_t   dec;
    rs_class_t      rs_class;
    logic           rd_is_x0;
    logic           fire;
    dispatch_pkt_t  next_pkt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field and immediate decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dec.opcode = head_inst.r_view.opcode;
        dec.funct3 = head_inst.r_view.funct3;
        dec.funct7 = head_inst.r_view.funct7;
        dec.i_imm  = {{21{head_inst.r_view.funct7[6]}}, head_inst.r_view.funct7[5:0],
                      head_inst.r_view.rs2};
        dec.s_imm  = {{21{head_inst.r_view.funct7[6]}}, head_inst.r_view.funct7[5:0],
                      head_inst.r_view.rd};
        dec.b_imm  = {{20{head_inst.r_view.funct7[6]}}, head_inst.r_view.rd[0],
                      head_inst.r_view.funct7[5:0], head_inst.r_view.rd[4:1], 1'b0};
        dec.u_imm  = {head_inst.u_view.upper, 12'h000};
        dec.j_imm  = {{12{head_inst.u_view.upper[19]}}, head_inst.u_view.upper[7:0],
                      head_inst.u_view.upper[8], head_inst.u_view.upper[18:9], 1'b0};
        dec.rd_s   = head_inst.r_view.rd;
        dec.rs1_s  = head_inst.r_view.rs1;
        dec.rs2_s  = head_inst.r_view.rs2;
        dec.inst   = head_inst;
    end

    // station select, only R-type with the M funct7 leaves the ALU
    always_comb begin
        rs_class = rs_alu;
        if (dec.opcode == op_b_reg && dec.funct7 == funct7_muldiv) begin
            case (dec.funct3)
                mult_div_f3_mul, mult_div_f3_mulh,
                mult_div_f3_mulhsu, mult_div_f3_mulhu: rs_class = rs_mul;
                mult_div_f3_div, mult_div_f3_divu,
                mult_div_f3_rem, mult_div_f3_remu:     rs_class = rs_div;
                default:                               rs_class = rs_alu;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stall decision and rename request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_is_x0 = (dec.rd_s == 5'd0);

    // any full station stalls, whichever one the head targets
    assign fire = !is_iqueue_empty && (!is_free_list_empty || rd_is_x0) && !rob_full
                  && !rs_full_add && !rs_full_mul && !rs_full_div;

    assign iq_dequeue = fire;
    assign fl_dequeue = fire && !rd_is_x0;  // x0 takes no register
    assign rat_we     = fire && !rd_is_x0;
    assign rd         = dec.rd_s;
    assign rs1        = dec.rs1_s;
    assign rs2        = dec.rs2_s;
    assign pd         = phys_reg;

    always_comb begin
        next_pkt.decode_info = dec;
        next_pkt.rs_class    = rs_class;
        next_pkt.pd          = rd_is_x0 ? '0 : pd;
        next_pkt.ps1         = ps1;
        next_pkt.ps2         = ps2;
        next_pkt.ps1_valid   = ps1_valid;
        next_pkt.ps2_valid   = ps2_valid;
        next_pkt.regf_we     = !rd_is_x0;
        next_pkt.rob_num     = rob_num;
    end

    // output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            dispatch_pkt <= next_pkt;
        end
    end

endmodule : rename_dispatch

// ==== rtl/rename_top.sv ====
`timescale 1ns/1ps

module rename_top #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS
)
(
    input   logic                                   clk,
    input   logic                                   reset,

    // fetch handshake
    input   logic                                   fetch_valid,
    input   rv32i_types::inst_u                     fetch_inst,
    output  logic                                   fetch_ready,

    // back-end flags
    input   logic                                   rob_full,
    input   logic                                   rs_full_add,
    input   logic                                   rs_full_mul,
    input   logic                                   rs_full_div,
    input   logic [rv32i_types::ROB_TAG_BITS-1:0]   rob_num,

    // completion and commit
    input   logic                                   cdb_valid,
    input   logic [PHYS_REG_BITS-1:0]               cdb_preg,
    input   logic                                   release_valid,
    input   logic [PHYS_REG_BITS-1:0]               release_preg,

    output  logic                                   dispatch_valid,
    output  rv32i_types::dispatch_pkt_t             dispatch_pkt
);

    import rv32i_types::*;

    inst_u                      head_inst;
    logic                       is_iqueue_empty, iq_dequeue;
    logic [PHYS_REG_BITS-1:0]   phys_reg;
    logic                       is_free_list_empty, fl_dequeue;
    logic [4:0]                 rd, rs1, rs2;
    logic [PHYS_REG_BITS-1:0]   pd, ps1, ps2;
    logic                       ps1_valid, ps2_valid, rat_we;

    inst_queue iq0 (
        .clk, .reset,
        .fetch_valid, .fetch_inst, .fetch_ready,
        .head_inst, .is_iqueue_empty, .iq_dequeue
    );

    free_list #(.PHYS_REG_BITS(PHYS_REG_BITS)) fl0 (
        .clk, .reset,
        .fl_dequeue, .phys_reg, .is_free_list_empty,
        .release_valid, .release_preg
    );

    rat #(.PHYS_REG_BITS(PHYS_REG_BITS)) rat0 (
        .clk, .reset,
        .rs1, .rs2, .ps1, .ps2, .ps1_valid, .ps2_valid,
        .rd, .rat_we, .pd,
        .cdb_valid, .cdb_preg
    );

    rename_dispatch #(.PHYS_REG_BITS(PHYS_REG_BITS)) rd0 (
        .clk, .reset,
        .head_inst, .is_iqueue_empty, .iq_dequeue,
        .phys_reg, .is_free_list_empty, .fl_dequeue,
        .rd, .rs1, .rs2, .pd, .rat_we,
        .ps1, .ps2, .ps1_valid, .ps2_valid,
        .rob_full, .rs_full_add, .rs_full_mul, .rs_full_div, .rob_num,
        .dispatch_valid, .dispatch_pkt
    );

endmodule : rename_top

// ==== tests/rename_checker.sv ====
`timescale 1ns/1ps

module rename_checker #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS
)
(
    input   logic                                   clk,
    input   logic                                   reset,
    input   logic                                   fetch_valid,
    input   logic [31:0]                            fetch_inst,
    input   logic                                   fetch_ready,
    input   logic                                   rob_full,
    input   logic                                   rs_full_add,
    input   logic                                   rs_full_mul,
    input   logic                                   rs_full_div,
    input   logic [rv32i_types::ROB_TAG_BITS-1:0]   rob_num,
    input   logic                                   cdb_valid,
    input   logic [PHYS_REG_BITS-1:0]               cdb_preg,
    input   logic                                   release_valid,
    input   logic [PHYS_REG_BITS-1:0]               release_preg,
    input   logic                                   dispatch_valid,
    input   rv32i_types::dispatch_pkt_t             dispatch_pkt
);

    import rv32i_types::*;

    localparam int IQ_DEPTH = 8;

    logic [31:0]               iq_model [$];
    logic [PHYS_REG_BITS-1:0]  fl_model [$];
    logic [PHYS_REG_BITS-1:0]  model_map [ARCH_REGS];
    logic                      model_ready [ARCH_REGS];
    logic [PHYS_REG_BITS-1:0]  retired_log [4096];     // old mappings, free to release
    int                        retired_cnt;
    int                        q_size;
    int                        error_count;
    int                        check_count;
    int                        dut_dispatch_count;
    dispatch_pkt_t             exp_pkt;
    logic                      exp_valid;

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        check_count++;
        if (exp_v !== act_v) begin
            error_count++;
            $display("Mismatch %s: expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    // M funct7 on a register op, funct3[2] splits divide from multiply
    function automatic rs_class_t class_of(input logic [31:0] w);
        if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000001) begin
            return w[14] ? rs_div : rs_mul;
        end
        return rs_alu;
    endfunction

    task automatic reset_model();
        iq_model.delete();
        fl_model.delete();
        for (int i = 0; i < (1 << PHYS_REG_BITS) - ARCH_REGS; i++) begin
            fl_model.push_back(PHYS_REG_BITS'(ARCH_REGS + i));
        end
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_map[i]   = PHYS_REG_BITS'(i);
            model_ready[i] = 1'b1;
        end
        retired_cnt = 0;
        q_size      = 0;
        exp_valid   = 1'b0;
    endtask

    task automatic compare_pkt();
        check_val("decode opcode", exp_pkt.decode_info.opcode, dispatch_pkt.decode_info.opcode);
        check_val("decode funct3", exp_pkt.decode_info.funct3, dispatch_pkt.decode_info.funct3);
        check_val("decode funct7", exp_pkt.decode_info.funct7, dispatch_pkt.decode_info.funct7);
        check_val("decode i_imm", exp_pkt.decode_info.i_imm, dispatch_pkt.decode_info.i_imm);
        check_val("decode s_imm", exp_pkt.decode_info.s_imm, dispatch_pkt.decode_info.s_imm);
        check_val("decode b_imm", exp_pkt.decode_info.b_imm, dispatch_pkt.decode_info.b_imm);
        check_val("decode u_imm", exp_pkt.decode_info.u_imm, dispatch_pkt.decode_info.u_imm);
        check_val("decode j_imm", exp_pkt.decode_info.j_imm, dispatch_pkt.decode_info.j_imm);
        check_val("decode rd", exp_pkt.decode_info.rd_s, dispatch_pkt.decode_info.rd_s);
        check_val("decode rs1", exp_pkt.decode_info.rs1_s, dispatch_pkt.decode_info.rs1_s);
        check_val("decode rs2", exp_pkt.decode_info.rs2_s, dispatch_pkt.decode_info.rs2_s);
        check_val("decode inst", exp_pkt.decode_info.inst, dispatch_pkt.decode_info.inst);
        check_val("classify rs_class", exp_pkt.rs_class, dispatch_pkt.rs_class);
        check_val("rename pd", exp_pkt.pd, dispatch_pkt.pd);
        check_val("rename ps1", exp_pkt.ps1, dispatch_pkt.ps1);
        check_val("rename ps2", exp_pkt.ps2, dispatch_pkt.ps2);
        check_val("rename regf_we", exp_pkt.regf_we, dispatch_pkt.regf_we);
        check_val("rename rob_num", exp_pkt.rob_num, dispatch_pkt.rob_num);
        check_val("ready ps1_valid", exp_pkt.ps1_valid, dispatch_pkt.ps1_valid);
        check_val("ready ps2_valid", exp_pkt.ps2_valid, dispatch_pkt.ps2_valid);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one clock edge of the reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic step_model();
        logic [31:0] w;
        logic [4:0]  rd, rs1, rs2;
        logic        fire;
        logic        room;
        w    = (iq_model.size() > 0) ? iq_model[0] : 32'h0;
        rd   = w[11:7];
        rs1  = w[19:15];
        rs2  = w[24:20];
        room = (iq_model.size() < IQ_DEPTH);
        fire = (iq_model.size() > 0) && (fl_model.size() > 0 || rd == 5'd0) && !rob_full
               && !rs_full_add && !rs_full_mul && !rs_full_div;
        check_val("flow fetch_ready", 32'(room), 32'(fetch_ready));
        exp_valid = fire;
        if (fire) begin
            exp_pkt.decode_info.opcode = w[6:0];
            exp_pkt.decode_info.funct3 = w[14:12];
            exp_pkt.decode_info.funct7 = w[31:25];
            exp_pkt.decode_info.i_imm  = {{20{w[31]}}, w[31:20]};
            exp_pkt.decode_info.s_imm  = {{20{w[31]}}, w[31:25], w[11:7]};
            exp_pkt.decode_info.b_imm  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            exp_pkt.decode_info.u_imm  = {w[31:12], 12'h000};
            exp_pkt.decode_info.j_imm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            exp_pkt.decode_info.rd_s   = rd;
            exp_pkt.decode_info.rs1_s  = rs1;
            exp_pkt.decode_info.rs2_s  = rs2;
            exp_pkt.decode_info.inst   = w;
            exp_pkt.rs_class  = class_of(w);
            exp_pkt.pd        = (rd == 5'd0) ? '0 : fl_model[0];
            exp_pkt.ps1       = model_map[rs1];
            exp_pkt.ps2       = model_map[rs2];
            exp_pkt.ps1_valid = model_ready[rs1] || (cdb_valid && model_map[rs1] == cdb_preg);
            exp_pkt.ps2_valid = model_ready[rs2] || (cdb_valid && model_map[rs2] == cdb_preg);
            exp_pkt.regf_we   = (rd != 5'd0);
            exp_pkt.rob_num   = rob_num;
            void'(iq_model.pop_front());
        end
        if (fetch_valid && room) begin
            iq_model.push_back(fetch_inst);
        end
        for (int i = 1; i < ARCH_REGS; i++) begin
            if (cdb_valid && model_map[i] == cdb_preg) begin
                model_ready[i] = 1'b1;                  // wakeup
            end
        end
        if (fire && rd != 5'd0) begin
            retired_log[retired_cnt] = model_map[rd];
            retired_cnt++;
            model_map[rd]   = fl_model.pop_front();     // rename wins over wakeup
            model_ready[rd] = 1'b0;
        end
        if (release_valid) begin
            fl_model.push_back(release_preg);
        end
        q_size = iq_model.size();
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            check_val("stall dispatch_valid", 32'(exp_valid), 32'(dispatch_valid));
            if (dispatch_valid) begin
                dut_dispatch_count++;
            end
            if (exp_valid && dispatch_valid) begin
                compare_pkt();
            end
            step_model();
        end
    end

endmodule : rename_checker

// ==== tests/rename_assert.sv ====
`timescale 1ns/1ps

module rename_assert #(
    parameter int HEAD_BITS = 32
)
(
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   pop,
    input   logic                   empty,
    input   logic [HEAD_BITS-1:0]   head
);

    int assert_failures = 0;

    // pushes land at the tail, so the head only moves on a pop
    head_held: assert property (@(posedge clk) disable iff (reset)
                                !pop && !empty |=> $stable(head))
        else begin
            assert_failures++;
            $error("ring head changed without a dequeue");
        end

    head_known: assert property (@(posedge clk) disable iff (reset)
                                 !empty |-> !$isunknown(head))
        else begin
            assert_failures++;
            $error("ring head is unknown while entries are held");
        end

    control_known: assert property (@(posedge clk) disable iff (reset) !$isunknown({pop, empty}))
        else begin
            assert_failures++;
            $error("ring control signal is unknown");
        end

endmodule : rename_assert

bind inst_queue rename_assert iq_chk (
    .clk, .reset,
    .pop(iq_dequeue), .empty(is_iqueue_empty), .head(head_inst)
);

bind rename_dispatch rename_assert #(.HEAD_BITS(PHYS_REG_BITS)) fl_chk (
    .clk, .reset,
    .pop(fl_dequeue), .empty(is_free_list_empty), .head(phys_reg)
);

// ==== tests/tb_rename.sv ====
`timescale 1ns/1ps

module tb_rename;

    import rv32i_types::*;

    localparam int PREG_BITS     = 6;
    localparam int NUM_INSTS     = 400;
    localparam int FETCH_LIMIT   = 6000;
    localparam int DRAIN_LIMIT   = 500;
    localparam int RELEASE_START = 150;   // lets the free list run dry first

    logic                       clk;
    logic                       reset;
    logic                       fetch_valid;
    inst_u                      fetch_inst;
    logic                       fetch_ready;
    logic                       rob_full, rs_full_add, rs_full_mul, rs_full_div;
    logic [ROB_TAG_BITS-1:0]    rob_num;
    logic                       cdb_valid;
    logic [PREG_BITS-1:0]       cdb_preg;
    logic                       release_valid;
    logic [PREG_BITS-1:0]       release_preg;
    logic                       dispatch_valid;
    dispatch_pkt_t              dispatch_pkt;

    logic [31:0]                lfsr;
    int                         sent, cycle, rel_idx, other_errors;

    rename_top #(.PHYS_REG_BITS(PREG_BITS)) dut0 (
        .clk, .reset,
        .fetch_valid, .fetch_inst, .fetch_ready,
        .rob_full, .rs_full_add, .rs_full_mul, .rs_full_div, .rob_num,
        .cdb_valid, .cdb_preg, .release_valid, .release_preg,
        .dispatch_valid, .dispatch_pkt
    );

    rename_checker #(.PHYS_REG_BITS(PREG_BITS)) chk0 (
        .clk, .reset,
        .fetch_valid, .fetch_inst, .fetch_ready,
        .rob_full, .rs_full_add, .rs_full_mul, .rs_full_div, .rob_num,
        .cdb_valid, .cdb_preg, .release_valid, .release_preg,
        .dispatch_valid, .dispatch_pkt
    );

    always #20 clk = ~clk;

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        logic [2:0]  kind;
        logic [1:0]  sel;
        w    = take_bits(32);     // random fields and immediates
        kind = 3'(take_bits(3));
        sel  = 2'(take_bits(2));
        case (kind)
            3'd0: begin
                w[6:0]   = op_b_reg;
                w[31:25] = {1'b0, w[30], 5'b00000};    // add/sub, srl/sra
            end
            3'd1: begin
                w[6:0]   = op_b_reg;
                w[31:25] = funct7_muldiv;
                w[14]    = 1'b0;
            end
            3'd2: begin
                w[6:0]   = op_b_reg;
                w[31:25] = funct7_muldiv;
                w[14]    = 1'b1;
            end
            3'd3: begin
                case (sel)
                    2'd0:    w[6:0] = op_b_imm;
                    2'd1:    w[6:0] = op_b_load;
                    2'd2:    w[6:0] = op_b_jalr;
                    default: w[6:0] = op_b_auipc;
                endcase
            end
            3'd4:    w[6:0] = op_b_store;
            3'd5:    w[6:0] = op_b_br;
            3'd6:    w[6:0] = op_b_lui;
            default: w[6:0] = op_b_jal;
        endcase
        if (take_bits(3) == 0) begin
            w[11:7] = 5'd0;
        end
        return w;
    endfunction

    // one clock of stimulus, inputs change 2 ns after the edge
    task automatic drive_cycle();
        logic       took;
        logic [4:0] r;
        @(negedge clk);
        took = fetch_valid && fetch_ready;
        @(posedge clk);
        #2;
        cycle++;
        if (took) begin
            sent++;
        end
        if (!fetch_valid || took) begin
            fetch_valid = 1'b0;
            if (sent < NUM_INSTS && take_bits(2) != 0) begin
                fetch_inst  = make_inst();
                fetch_valid = 1'b1;
            end
        end
        rob_full    = (take_bits(4) == 0);
        rs_full_add = (take_bits(3) == 0);
        rs_full_mul = (take_bits(3) == 0);
        rs_full_div = (take_bits(3) == 0);
        rob_num     = ROB_TAG_BITS'(take_bits(ROB_TAG_BITS));
        cdb_valid   = (take_bits(1) != 0);
        r           = 5'(take_bits(5));
        cdb_preg    = chk0.model_map[r];          // only mapped registers complete
        release_valid = 1'b0;
        if (cycle >= RELEASE_START && rel_idx < chk0.retired_cnt && take_bits(1) != 0) begin
            release_valid = 1'b1;
            release_preg  = chk0.retired_log[rel_idx];
            rel_idx++;
        end
    endtask

    initial begin
        int waited;
        lfsr          = 32'd97868;
        clk           = 1'b0;
        reset         = 1'b1;
        fetch_valid   = 1'b0;
        fetch_inst    = '0;
        rob_full      = 1'b0;
        rs_full_add   = 1'b0;
        rs_full_mul   = 1'b0;
        rs_full_div   = 1'b0;
        rob_num       = '0;
        cdb_valid     = 1'b0;
        cdb_preg      = '0;
        release_valid = 1'b0;
        release_preg  = '0;
        sent          = 0;
        cycle         = 0;
        rel_idx       = 0;
        other_errors  = 0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        waited = 0;
        while (sent < NUM_INSTS && waited < FETCH_LIMIT) begin
            drive_cycle();
            waited++;
        end
        if (sent < NUM_INSTS) begin
            $display("Timeout: fetch accepted only %0d of %0d instructions", sent, NUM_INSTS);
            other_errors++;
        end

        waited = 0;
        while ((chk0.q_size > 0 || chk0.exp_valid) && waited < DRAIN_LIMIT) begin
            drive_cycle();
            waited++;
        end
        if (chk0.q_size > 0 || chk0.exp_valid) begin
            $display("Timeout: %0d instructions never dispatched", chk0.q_size);
            other_errors++;
        end
        if (chk0.dut_dispatch_count != sent) begin
            $display("Dispatch count %0d differs from %0d accepted instructions",
                     chk0.dut_dispatch_count, sent);
            other_errors++;
        end
        other_errors += dut0.iq0.iq_chk.assert_failures + dut0.rd0.fl_chk.assert_failures;

        $display("checks %0d, mismatches %0d, other errors %0d",
                 chk0.check_count, chk0.error_count, other_errors);
        if (chk0.error_count == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_rename

// ==== tb.f ====
rtl/rv32i_types.sv
rtl/inst_queue.sv
rtl/free_list.sv
rtl/rat.sv
rtl/rename_dispatch.sv
rtl/rename_top.sv
tests/rename_checker.sv
tests/rename_assert.sv
tests/tb_rename.sv

// ==== Bender.yml ====
package:
  name: rename_frontend

sources:
  - rtl/rv32i_types.sv
  - rtl/inst_queue.sv
  - rtl/free_list.sv
  - rtl/rat.sv
  - rtl/rename_dispatch.sv
  - rtl/rename_top.sv
  - target: test
    files:
      - tests/rename_checker.sv
      - tests/rename_assert.sv
      - tests/tb_rename.sv
